/* verilog/mem_subsys_pkg.sv */
`default_nettype none

package mem_subsys_pkg;

    // memory geometry
    localparam int SDRAMW  = 12;  // word address bits, 4k words
    localparam int MEM_DW  = 16;  // one memory word
    localparam int NPORTS  = 3;   // cpu side requesters on the slot
    localparam int MEM_LAT = 4;   // cycles from start to read data

    // one request as it travels from a requester through the arbiter
    typedef struct packed {
        logic [SDRAMW-1:0] addr;   // absolute word address, region offset already added
        logic              rnw;    // 1 read, 0 write
        logic [MEM_DW-1:0] wdata;  // narrow ports arrive zero extended
    } mem_req_t;

    // backend answer, shared by reads and writes
    typedef struct packed {
        logic              valid;  // one cycle, read data ready or write done
        logic [MEM_DW-1:0] rdata;  // only meaningful for reads
    } mem_rsp_t;

endpackage

`default_nettype wire

/* verilog/cpu_rq.sv */
`timescale 1ns/1ps
`default_nettype none

// one cpu side port
// the cpu decoder holds addr_ok high from the access until data_ok
// each rising edge of addr_ok becomes exactly one memory request
module cpu_rq #(
    parameter int AW       = 10,
    parameter int DW       = 8,
    parameter bit FASTWR   = 1'b0,  // ack a write once the slot takes it
    parameter int OFFSET_W = mem_subsys_pkg::SDRAMW
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic [AW-1:0]            addr,      // cpu word address
    input  wire logic [OFFSET_W-1:0]      offset,    // region base, static
    input  wire logic                     addr_ok,   // chip select level
    input  wire logic                     wrin,      // 1 write, 0 read
    input  wire logic [DW-1:0]            wrdata,
    input  wire logic                     we,        // slot owned by this port
    input  wire logic                     dst,       // slot finished, rdata valid
    input  wire logic [mem_subsys_pkg::MEM_DW-1:0] rdata,
    output logic                          req,       // pending request level
    output mem_subsys_pkg::mem_req_t      rq,
    output logic                          data_ok,   // access done, held until addr_ok drops
    output logic [DW-1:0]                 dout
);

    localparam int SW = mem_subsys_pkg::SDRAMW;
    localparam int MW = mem_subsys_pkg::MEM_DW;

    logic          last_cs;     // addr_ok one cycle back
    logic          pend;        // edge arrived while the port was still busy
    logic          busy;        // op queued or in the slot
    logic          we_q;        // for the first cycle of we
    logic          cs_posedge;
    logic          launch;      // start a new op this cycle
    logic [SW-1:0] addr_ext;
    logic [SW-1:0] offset_ext;

    assign addr_ext   = SW'(addr);    // zero extend cpu address
    assign offset_ext = SW'(offset);
    assign cs_posedge = addr_ok && !last_cs;

    // with FASTWR the cpu may come back while its write still sits in the slot
    // such an edge is kept in pend and launched once the slot lets go
    assign launch = addr_ok && !busy && (cs_posedge || pend);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_cs <= 1'b0;
            pend    <= 1'b0;
            busy    <= 1'b0;
            we_q    <= 1'b0;
            req     <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            last_cs <= addr_ok;
            we_q    <= we;
            pend    <= addr_ok && busy && (pend || cs_posedge);  // lost if cs drops

            if (launch) begin
                busy    <= 1'b1;
                req     <= 1'b1;
                data_ok <= 1'b0;
            end

            if (we) req <= 1'b0;  // arbiter has taken it

            // background write, cpu can move on
            if (FASTWR && we && !we_q && !rq.rnw) data_ok <= 1'b1;

            if (dst) begin
                busy <= 1'b0;
                if (rq.rnw || !FASTWR) data_ok <= 1'b1;  // fast writes already acked
            end

            if (!addr_ok) data_ok <= 1'b0;  // cpu released the chip select
        end
    end

    // request payload and read data
    always_ff @(posedge clk) begin
        if (launch) begin
            rq.addr  <= addr_ext + offset_ext;  // region mapping
            rq.rnw   <= ~wrin;
            rq.wdata <= MW'(wrdata);            // no byte masks, upper bits stored as zero
        end
        if (dst && rq.rnw) dout <= rdata[DW-1:0];  // narrow ports see the low part
    end

endmodule

`default_nettype wire

/* verilog/slot_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// round robin owner of the single memory slot
// one operation at a time, the backend therefore never sees start while busy
module slot_arbiter (
    input  wire logic                                        clk,
    input  wire logic                                        rst,
    input  wire logic [mem_subsys_pkg::NPORTS-1:0]           req,
    input  wire mem_subsys_pkg::mem_req_t [mem_subsys_pkg::NPORTS-1:0] rq,
    input  wire mem_subsys_pkg::mem_rsp_t                    rsp,
    output logic [mem_subsys_pkg::NPORTS-1:0]                we,     // owner level
    output logic [mem_subsys_pkg::NPORTS-1:0]                dst,    // done strobe per port
    output logic                                             start,  // one cycle, to backend
    output mem_subsys_pkg::mem_req_t                         mreq
);

    localparam int N  = mem_subsys_pkg::NPORTS;
    localparam int PW = (N > 1) ? $clog2(N) : 1;

    logic [PW-1:0] last;   // port served most recently, rr pointer
    logic [PW-1:0] sel;    // next port to serve
    logic          found;  // some port is asking
    logic          idle;

    assign idle = ~|we;  // we doubles as the owner register

    // response goes back to the owner only
    assign dst = we & {N{rsp.valid}};

    // search starts right after the last served port and wraps
    always_comb begin : pick
        int idx;
        sel   = last;
        found = 1'b0;
        for (int i = 1; i <= N; i++) begin
            idx = int'(last) + i;
            if (idx >= N) begin
                idx = idx - N;
            end
            if (!found && req[idx]) begin
                sel   = PW'(idx);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            we    <= '0;
            start <= 1'b0;
            last  <= PW'(N - 1);  // port 0 wins the first round
        end else begin
            start <= 1'b0;
            if (idle && found) begin
                start <= 1'b1;
                we    <= N'(1) << sel;  // we rises together with start
                last  <= sel;
            end else if (rsp.valid) begin
                we <= '0;  // still high in the dst cycle, idle from the next one
            end
        end
    end

    // registered request towards the backend
    always_ff @(posedge clk) begin
        if (idle && found) mreq <= rq[sel];
    end

endmodule

`default_nettype wire

/* verilog/mem_backend.sv */
`timescale 1ns/1ps
`default_nettype none

// stand in for the sdram controller
// plain word array, reads come back after a fixed latency
module mem_backend #(
    parameter int LAT = mem_subsys_pkg::MEM_LAT  // start to rsp.valid for reads, >= 1
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     start,  // new op, backend must be idle
    input  wire mem_subsys_pkg::mem_req_t mreq,
    output mem_subsys_pkg::mem_rsp_t      rsp
);

    localparam int SW = mem_subsys_pkg::SDRAMW;
    localparam int MW = mem_subsys_pkg::MEM_DW;

    logic [MW-1:0]  mem [2**SW];   // the whole address space
    logic [LAT-1:0] rd_vld;        // read tokens moving towards rsp
    logic [MW-1:0]  rd_dat [LAT];  // data riding alongside the tokens
    logic           wr_done;       // write ack, one cycle after start
    logic           rd_start;
    logic           wr_start;

    assign rd_start = start && mreq.rnw;
    assign wr_start = start && !mreq.rnw;

    // array port, synchronous read feeds the first latency stage
    always_ff @(posedge clk) begin
        if (wr_start) begin
            mem[mreq.addr] <= mreq.wdata;
        end
        if (rd_start) begin
            rd_dat[0] <= mem[mreq.addr];
        end
    end

    // remaining latency stages, payload only
    always_ff @(posedge clk) begin
        for (int k = 1; k < LAT; k++) begin
            rd_dat[k] <= rd_dat[k-1];
        end
    end

    // token shift register, several reads could be in flight here
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_vld  <= '0;
            wr_done <= 1'b0;
        end else begin
            rd_vld  <= LAT'({rd_vld, rd_start});  // oldest token falls off the top
            wr_done <= wr_start;
        end
    end

    // a read token leaves stage LAT-1 exactly LAT cycles after its start
    // reads and write acks cannot meet here while the arbiter serializes ops
    assign rsp.valid = rd_vld[LAT-1] | wr_done;
    assign rsp.rdata = rd_dat[LAT-1];

endmodule

`default_nettype wire

/* verilog/mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

// three cpu ports sharing one memory through the slot arbiter
// port regions are placed by the per port offset inputs
module mem_subsys #(
    parameter int AW      = 10,    // cpu word address width, all ports
    parameter int DW0     = 8,
    parameter int DW1     = 16,
    parameter int DW2     = 8,
    parameter bit FASTWR0 = 1'b0,
    parameter bit FASTWR1 = 1'b0,
    parameter bit FASTWR2 = 1'b1,  // port 2 writes run in the background
    parameter int LAT     = mem_subsys_pkg::MEM_LAT
) (
    input  wire logic                                     clk,
    input  wire logic                                     rst,
    input  wire logic [mem_subsys_pkg::NPORTS-1:0]        addr_ok,
    input  wire logic [mem_subsys_pkg::NPORTS-1:0]        wrin,
    input  wire logic [mem_subsys_pkg::NPORTS-1:0][AW-1:0] addr,
    input  wire logic [mem_subsys_pkg::NPORTS-1:0][mem_subsys_pkg::SDRAMW-1:0] offset,
    input  wire logic [DW0-1:0]                           wrdata0,
    input  wire logic [DW1-1:0]                           wrdata1,
    input  wire logic [DW2-1:0]                           wrdata2,
    output wire logic [mem_subsys_pkg::NPORTS-1:0]        data_ok,
    output wire logic [DW0-1:0]                           dout0,
    output wire logic [DW1-1:0]                           dout1,
    output wire logic [DW2-1:0]                           dout2
);

    localparam int N = mem_subsys_pkg::NPORTS;

    wire logic [N-1:0]                    req;    // per port request levels
    wire logic [N-1:0]                    we;     // slot owner
    wire logic [N-1:0]                    dst;    // slot done strobes
    wire mem_subsys_pkg::mem_req_t [N-1:0] rq;    // one request per port
    wire logic                            start;
    wire mem_subsys_pkg::mem_req_t        mreq;   // arbiter to backend
    wire mem_subsys_pkg::mem_rsp_t        rsp;    // backend answer

    cpu_rq #(
        .AW(AW), .DW(DW0), .FASTWR(FASTWR0), .OFFSET_W(mem_subsys_pkg::SDRAMW)
    ) i_rq0 (
        .clk(clk), .rst(rst),
        .addr(addr[0]), .offset(offset[0]), .addr_ok(addr_ok[0]), .wrin(wrin[0]),
        .wrdata(wrdata0), .we(we[0]), .dst(dst[0]), .rdata(rsp.rdata),
        .req(req[0]), .rq(rq[0]), .data_ok(data_ok[0]), .dout(dout0)
    );

    cpu_rq #(
        .AW(AW), .DW(DW1), .FASTWR(FASTWR1), .OFFSET_W(mem_subsys_pkg::SDRAMW)
    ) i_rq1 (
        .clk(clk), .rst(rst),
        .addr(addr[1]), .offset(offset[1]), .addr_ok(addr_ok[1]), .wrin(wrin[1]),
        .wrdata(wrdata1), .we(we[1]), .dst(dst[1]), .rdata(rsp.rdata),
        .req(req[1]), .rq(rq[1]), .data_ok(data_ok[1]), .dout(dout1)
    );

    cpu_rq #(
        .AW(AW), .DW(DW2), .FASTWR(FASTWR2), .OFFSET_W(mem_subsys_pkg::SDRAMW)
    ) i_rq2 (
        .clk(clk), .rst(rst),
        .addr(addr[2]), .offset(offset[2]), .addr_ok(addr_ok[2]), .wrin(wrin[2]),
        .wrdata(wrdata2), .we(we[2]), .dst(dst[2]), .rdata(rsp.rdata),
        .req(req[2]), .rq(rq[2]), .data_ok(data_ok[2]), .dout(dout2)
    );

    // single slot, round robin between the ports
    slot_arbiter i_arb (
        .clk(clk), .rst(rst),
        .req(req), .rq(rq), .rsp(rsp),
        .we(we), .dst(dst), .start(start), .mreq(mreq)
    );

    mem_backend #(
        .LAT(LAT)
    ) i_mem (
        .clk(clk), .rst(rst),
        .start(start), .mreq(mreq), .rsp(rsp)
    );

endmodule

`default_nettype wire

/* testbench/mem_subsys_sva.sv */
`timescale 1ns/1ps
`default_nettype none

// slot protocol checks, sits inside slot_arbiter
module mem_subsys_sva (
    input wire logic                                clk,
    input wire logic                                rst,
    input wire logic [mem_subsys_pkg::NPORTS-1:0]   we,
    input wire logic [mem_subsys_pkg::NPORTS-1:0]   dst,
    input wire logic                                start,
    input wire mem_subsys_pkg::mem_req_t            mreq,
    input wire mem_subsys_pkg::mem_rsp_t            rsp
);

    localparam int LAT = mem_subsys_pkg::MEM_LAT;  // backend read latency

    logic op_open;  // start seen, backend response not back yet

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_open <= 1'b0;
        end else if (start) begin
            op_open <= 1'b1;
        end else if (rsp.valid) begin
            op_open <= 1'b0;
        end
    end

    a_we_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(we))
        else $error("more than one port owns the slot");

    // the backend holds one op, a new start waits for the previous response
    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !op_open)
        else $error("start issued while the previous operation was still in the backend");

    // every response is steered to exactly one owning port
    a_dst_owner: assert property (@(posedge clk) disable iff (rst) rsp.valid |-> $onehot(dst))
        else $error("backend response arrived with no single port owning the slot");

    a_rd_lat: assert property (@(posedge clk) disable iff (rst)
        start && mreq.rnw |-> ##LAT rsp.valid)
        else $error("read response not at the fixed latency");

    a_wr_ack: assert property (@(posedge clk) disable iff (rst)
        start && !mreq.rnw |=> rsp.valid)
        else $error("write ack missing one cycle after start");

endmodule

bind slot_arbiter mem_subsys_sva i_sva (
    .clk(clk), .rst(rst), .we(we), .dst(dst),
    .start(start), .mreq(mreq), .rsp(rsp)
);

`default_nettype wire

/* testbench/tb_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench for the three port memory subsystem
// a word array model follows every write as it is issued, reads compare against it
module tb_mem_subsys;

    localparam int N       = mem_subsys_pkg::NPORTS;
    localparam int SW      = mem_subsys_pkg::SDRAMW;
    localparam int AW      = 10;
    localparam int TIMEOUT = 200;  // cycles allowed per access
    localparam int NOPS    = 16;   // random ops per port

    logic                 clk;
    logic                 rst;
    logic [N-1:0]         addr_ok;
    logic [N-1:0]         wrin;
    logic [N-1:0][AW-1:0] addr;
    logic [N-1:0][SW-1:0] offset;
    logic [7:0]           wrdata0;
    logic [15:0]          wrdata1;
    logic [7:0]           wrdata2;
    wire logic [N-1:0]    data_ok;
    wire logic [7:0]      dout0;
    wire logic [15:0]     dout1;
    wire logic [7:0]      dout2;

    logic [15:0] model [2**SW];  // reference memory, full words
    bit          known [2**SW];  // word has been written at least once
    integer      seed = 32'h1dbf_2036;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed = 0;

    // random stream, drawn before the ports run so the order is fixed
    logic [AW-1:0] r_addr [N][NOPS];
    logic [15:0]   r_data [N][NOPS];
    bit            r_wr   [N][NOPS];

    mem_subsys i_dut (
        .clk(clk), .rst(rst),
        .addr_ok(addr_ok), .wrin(wrin), .addr(addr), .offset(offset),
        .wrdata0(wrdata0), .wrdata1(wrdata1), .wrdata2(wrdata2),
        .data_ok(data_ok), .dout0(dout0), .dout1(dout1), .dout2(dout2)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // one cpu access on port p, chip select held until data_ok
    task automatic cpu_access(input int p, input bit wr, input logic [AW-1:0] a,
                              input logic [15:0] d, output int lat);
        logic [SW-1:0] wa;
        logic [15:0]   mask;
        logic [15:0]   exp_val;
        logic [15:0]   got;
        bit            done;
        wa      = SW'(a) + offset[p];                  // region mapping
        mask    = (p == 1) ? 16'hffff : 16'h00ff;      // only port 1 is 16 bit wide
        exp_val = model[wa] & mask;
        if (wr) begin
            model[wa] = d & mask;  // narrow write lands zero extended
            known[wa] = 1'b1;
        end
        @(posedge clk);
        addr[p]    <= a;
        wrin[p]    <= wr;
        case (p)
            0:       wrdata0 <= d[7:0];
            1:       wrdata1 <= d;
            default: wrdata2 <= d[7:0];
        endcase
        addr_ok[p] <= 1'b1;
        done = 1'b0;
        lat  = 0;
        while (!done && lat < TIMEOUT) begin
            @(negedge clk);  // outputs settled mid cycle
            lat++;
            done = data_ok[p];
        end
        if (!done) begin
            $display("port %0d got no data_ok within %0d cycles, time %0t", p, TIMEOUT, $time);
            errors++;
        end else if (!wr) begin
            case (p)
                0:       got = 16'(dout0);
                1:       got = dout1;
                default: got = 16'(dout2);
            endcase
            checks++;
            assert (got == exp_val) else begin
                $display("Mismatch at %0t: port %0d word %h read %h, expected %h",
                         $time, p, wa, got, exp_val);
                errors++;
            end
        end
        @(posedge clk);
        addr_ok[p] <= 1'b0;  // release, data_ok clears next edge
    endtask

    // precomputed random sequence of one port
    task automatic random_run(input int p);
        int lat;
        for (int i = 0; i < NOPS; i++) begin
            cpu_access(p, r_wr[p][i], r_addr[p][i], r_data[p][i], lat);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        if (errors != err0) failed++;
        $display("test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "FAIL");
    endtask

    initial begin : main
        int            err0;
        int            lat;
        int            lats [N];
        logic [AW-1:0] a;
        logic [AW-1:0] ca [N];
        logic [15:0]   d0;
        logic [15:0]   d1;
        logic [15:0]   d2;
        logic [SW-1:0] wa;

        addr_ok = '0;
        wrin    = '0;
        addr    = '0;
        wrdata0 = '0;
        wrdata1 = '0;
        wrdata2 = '0;
        offset  = {SW'(2048), SW'(1024), SW'(0)};  // disjoint regions per port
        rst     = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // 1: nothing completes without an access
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            checks++;
            assert (data_ok == '0) else begin
                $display("Mismatch at %0t: data_ok %b with no access, expected 000",
                         $time, data_ok);
                errors++;
            end
        end
        report_test("data_ok low after reset", err0);

        // 2: full word round trip on the wide port
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            a  = AW'($random(seed));
            d0 = 16'($random(seed));
            d1 = 16'($random(seed));
            cpu_access(1, 1'b1, a, d0, lat);
            cpu_access(1, 1'b0, a, 16'h0, lat);
            cpu_access(1, 1'b1, a, d1, lat);  // overwrite, last write wins
            cpu_access(1, 1'b0, a, 16'h0, lat);
        end
        report_test("port 1 read after write", err0);

        // 3: byte port, also peek at the stored word for the zero upper byte
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            a  = AW'($random(seed));
            d0 = 16'($random(seed));  // upper byte is noise the port must drop
            wa = SW'(a) + offset[0];
            cpu_access(0, 1'b1, a, d0, lat);
            checks++;
            assert (i_dut.i_mem.mem[wa] == model[wa]) else begin
                $display("Mismatch at %0t: stored word %h is %h, expected %h",
                         $time, wa, i_dut.i_mem.mem[wa], model[wa]);
                errors++;
            end
            cpu_access(0, 1'b0, a, 16'h0, lat);
        end
        report_test("port 0 byte access", err0);

        // 4: same cpu address on ports 0 and 2 lands in separate words
        err0 = errors;
        a  = AW'($random(seed));
        d0 = 16'($random(seed));
        d2 = 16'($random(seed));
        cpu_access(0, 1'b1, a, d0, lat);
        cpu_access(2, 1'b1, a, d2, lat);
        cpu_access(0, 1'b0, a, 16'h0, lat);
        cpu_access(2, 1'b0, a, 16'h0, lat);
        cpu_access(0, 1'b1, a, ~d0, lat);  // must not leak into port 2
        cpu_access(2, 1'b0, a, 16'h0, lat);
        report_test("offset mapping", err0);

        // 5: all three chip selects rise on the same edge
        err0 = errors;
        for (int p = 0; p < N; p++) ca[p] = AW'($random(seed));
        d0 = 16'($random(seed));
        d1 = 16'($random(seed));
        d2 = 16'($random(seed));
        fork
            cpu_access(0, 1'b1, ca[0], d0, lats[0]);
            cpu_access(1, 1'b1, ca[1], d1, lats[1]);
            cpu_access(2, 1'b1, ca[2], d2, lats[2]);
        join
        fork
            cpu_access(0, 1'b0, ca[0], 16'h0, lats[0]);
            cpu_access(1, 1'b0, ca[1], 16'h0, lats[1]);
            cpu_access(2, 1'b0, ca[2], 16'h0, lats[2]);
        join
        report_test("contention", err0);

        // 6: fast write ack, edge plus req plus start plus ack stage on an idle slot
        err0 = errors;
        for (int i = 0; i < 3; i++) begin
            a  = AW'($random(seed));
            d2 = 16'($random(seed));
            cpu_access(2, 1'b1, a, d2, lat);
            checks++;
            assert (lat == 4) else begin
                $display("Mismatch at %0t: port 2 write acked after %0d cycles, expected 4",
                         $time, lat);
                errors++;
            end
            cpu_access(2, 1'b0, a, 16'h0, lat);  // straight after the ack
        end
        report_test("port 2 fast write", err0);

        // random traffic, reads only hit words written earlier in the same port
        err0 = errors;
        for (int p = 0; p < N; p++) begin
            for (int i = 0; i < NOPS; i++) begin
                r_addr[p][i] = AW'($random(seed)) & AW'('h1f);  // small set, many hits
                r_data[p][i] = 16'($random(seed));
                r_wr[p][i]   = 1'($random(seed));
                wa = SW'(r_addr[p][i]) + offset[p];
                if (!known[wa]) r_wr[p][i] = 1'b1;
                if (r_wr[p][i]) known[wa] = 1'b1;
            end
        end
        fork
            random_run(0);
            random_run(1);
            random_run(2);
        join
        report_test("random traffic", err0);

        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_subsys.f */
verilog/mem_subsys_pkg.sv
verilog/cpu_rq.sv
verilog/slot_arbiter.sv
verilog/mem_backend.sv
verilog/mem_subsys.sv
testbench/mem_subsys_sva.sv
testbench/tb_mem_subsys.sv

/* Bender.yml */
# memory request subsystem, three cpu ports on one slot
package:
  name: mem_subsys

sources:
  # design, package first
  - verilog/mem_subsys_pkg.sv
  - verilog/cpu_rq.sv
  - verilog/slot_arbiter.sv
  - verilog/mem_backend.sv
  - verilog/mem_subsys.sv

  # simulation only
  - target: test
    files:
      - testbench/mem_subsys_sva.sv
      - testbench/tb_mem_subsys.sv

# top modules: mem_subsys for synthesis, tb_mem_subsys for simulation
